// File: compile.f
design/aesTypesPkg.sv
design/aesGfPkg.sv
design/aesRoundFunc.sv
design/aesKeySchedule.sv
design/aesRoundCtrl.sv
design/aesEncryptTop.sv
verif/aesChecker.sv
verif/aesTb.sv

// File: verif/aesTb.sv
//////////////////////////////////////////////////////////////////////
// AES-128 engine testbench
// Known and random vectors with output stalls and a mid-run reset
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numRandom     = 200;
  localparam int numVectors    = numRandom + 3;
  localparam int resetCycles   = 8;
  localparam int abortCycles   = 8;
  localparam int knownStall    = 3;
  // Model check, known vector, random vectors and the post-reset vector
  localparam int expectedTests = numRandom + 3;

  logic                clock;
  logic                arstN;
  aesTypesPkg::aesIn_t inData;
  logic                inValid;
  logic                inReady;
  aesTypesPkg::block_t outData;
  logic                outValid;
  logic                outReady;
  int                  tests;
  int                  errors;
  int                  stalls [numRandom];
  int                  stallSum;

  aesEncryptTop DUT (
    .clock    (clock),
    .arstN    (arstN),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

  aesChecker chk (
    .clock    (clock),
    .arstN    (arstN),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady),
    .tests    (tests),
    .errors   (errors)
  );

  always #2 clock = ~clock;

  function automatic logic [127:0] randBlock();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic runWatchdog(input int limitCycles);
    repeat (limitCycles) @(posedge clock);
    $display("Timeout: simulation still running after %0d clock cycles", limitCycles);
    $display(">>> FAIL");
    $finish;
  endtask

  // One block through both handshakes, sink stalls for the given cycles
  task automatic sendVector(input logic [127:0] plaintext, input logic [127:0] key,
                            input int stall);
    @(negedge clock);
    inData.plaintext = plaintext;
    inData.key       = key;
    inValid          = 1'b1;
    while (!inReady)
      @(negedge clock);
    @(negedge clock);
    inValid = 1'b0;
    // Input is ignored while busy, so keep it changing
    while (!outValid)
    begin
      inData = {randBlock(), randBlock()};
      @(negedge clock);
    end
    repeat (stall) @(negedge clock);
    outReady = 1'b1;
    @(negedge clock);
    outReady = 1'b0;
  endtask

  task automatic abortMidRun();
    @(negedge clock);
    inData  = {randBlock(), randBlock()};
    inValid = 1'b1;
    @(negedge clock);
    inValid = 1'b0;
    repeat (4) @(negedge clock);
    arstN = 1'b0;
    repeat (2) @(negedge clock);
    arstN = 1'b1;
  endtask

  initial
  begin
    void'($urandom(38756));
    clock    = 1'b0;
    arstN    = 1'b0;
    inData   = '0;
    inValid  = 1'b0;
    outReady = 1'b0;
    stallSum = knownStall;
    for (int i = 0; i < numRandom; i++)
    begin
      stalls[i] = $urandom_range(8, 0);
      stallSum  = stallSum + stalls[i];
    end
    fork
      runWatchdog(2 * (numVectors * 12 + stallSum + resetCycles + abortCycles));
    join_none
    repeat (resetCycles) @(negedge clock);
    arstN = 1'b1;
    sendVector(128'h00112233445566778899aabbccddeeff,
               128'h000102030405060708090a0b0c0d0e0f, knownStall);
    for (int i = 0; i < numRandom; i++)
      sendVector(randBlock(), randBlock(), stalls[i]);
    abortMidRun();
    sendVector(randBlock(), randBlock(), 2);
    repeat (4) @(negedge clock);
    if (tests != expectedTests)
      $display("Only %0d of %0d tests completed", tests, expectedTests);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0 && tests == expectedTests)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule : aesTb

`default_nettype wire

// File: verif/aesChecker.sv
//////////////////////////////////////////////////////////////////////
// AES testbench checker
// Reference model, expected-result queue and handshake checks
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesChecker (
  input  logic                clock,
  input  logic                arstN,
  input  aesTypesPkg::aesIn_t inData,
  input  logic                inValid,
  input  logic                inReady,
  input  aesTypesPkg::block_t outData,
  input  logic                outValid,
  input  logic                outReady,
  output int                  tests,
  output int                  errors
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int latency = 10;

  logic [7:0]          sboxTable [256];
  aesTypesPkg::block_t expQ [$];
  aesTypesPkg::block_t heldData;
  logic                stallSeen;
  logic                busy;
  logic                riseSeen;
  int                  cycle;
  int                  acceptCycle;
  int                  outCount;

  function automatic logic [7:0] gfMult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] prod;
    prod = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        prod = prod ^ a;
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return prod;
  endfunction

  // FIPS-197 cipher on a column-major byte array, key expanded up front
  function automatic logic [127:0] aesRef(input logic [127:0] pt, input logic [127:0] key);
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [7:0] rk [176];
    logic [7:0] rc;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 16; i++)
      rk[i] = key[127 - 8*i -: 8];
    for (int i = 16; i < 176; i += 4)
    begin
      if (i % 16 == 0)
      begin
        rk[i]     = rk[i - 16] ^ sboxTable[rk[i - 3]] ^ rc;
        rk[i + 1] = rk[i - 15] ^ sboxTable[rk[i - 2]];
        rk[i + 2] = rk[i - 14] ^ sboxTable[rk[i - 1]];
        rk[i + 3] = rk[i - 13] ^ sboxTable[rk[i - 4]];
        rc = gfMult(rc, 8'h02);
      end
      else
        for (int j = 0; j < 4; j++)
          rk[i + j] = rk[i + j - 16] ^ rk[i + j - 4];
    end
    for (int i = 0; i < 16; i++)
      s[i] = pt[127 - 8*i -: 8] ^ rk[i];
    for (int r = 1; r <= 10; r++)
    begin
      // Byte i sits in row i%4, which shifts left by its row number
      for (int i = 0; i < 16; i++)
        t[i] = sboxTable[s[(i + 4*(i % 4)) % 16]];
      for (int c = 0; c < 4; c++)
        for (int w = 0; w < 4; w++)
          s[4*c + w] = (r == 10) ? t[4*c + w] :
            gfMult(t[4*c + w], 8'h02) ^ gfMult(t[4*c + (w + 1) % 4], 8'h03) ^
            t[4*c + (w + 2) % 4] ^ t[4*c + (w + 3) % 4];
      for (int i = 0; i < 16; i++)
        s[i] = s[i] ^ rk[16*r + i];
    end
    for (int i = 0; i < 16; i++)
      ct[127 - 8*i -: 8] = s[i];
    return ct;
  endfunction

  initial
  begin
    logic [7:0] inv;
    logic [7:0] sb;
    logic [127:0] model;
    tests    = 0;
    errors   = 0;
    busy     = 1'b0;
    riseSeen = 1'b0;
    stallSeen = 1'b0;
    cycle    = 0;
    outCount = 0;
    // Inverse by search, then the affine map bit by bit
    for (int x = 0; x < 256; x++)
    begin
      inv = 8'h00;
      for (int y = 1; y < 256; y++)
        if (gfMult(8'(x), 8'(y)) == 8'h01)
          inv = 8'(y);
      for (int i = 0; i < 8; i++)
        sb[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8] ^
                inv[(i + 7) % 8] ^ ((8'h63 >> i) & 1'b1);
      sboxTable[x] = sb;
    end
    model = aesRef(128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f);
    tests = tests + 1;
    if (model !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
    begin
      errors = errors + 1;
      $display("[FAIL] modelCheck expected %h actual %h",
               128'h69c4e0d86a7b0430d8cdb78070b4c55a, model);
    end
    else
      $display("[PASS] modelCheck");
  end

  always @(posedge clock)
  begin
    string name;
    aesTypesPkg::block_t expected;
    cycle = cycle + 1;
    if (!arstN)
    begin
      // Aborted block leaves nothing behind
      expQ.delete();
      busy      = 1'b0;
      riseSeen  = 1'b0;
      stallSeen = 1'b0;
      if (outValid || !inReady)
      begin
        errors = errors + 1;
        $display("Reset did not clear outValid and raise inReady at cycle %0d", cycle);
      end
    end
    else
    begin
      name = (outCount == 0) ? "knownVector" : $sformatf("vector%0d", outCount);
      if (busy && inReady)
      begin
        errors = errors + 1;
        $display("inReady went high while a block was in flight at cycle %0d", cycle);
      end
      if (stallSeen && (!outValid || outData !== heldData))
      begin
        errors = errors + 1;
        $display("Output changed during a stall at cycle %0d", cycle);
      end
      stallSeen = outValid && !outReady;
      heldData  = outData;
      if (outValid && busy && !riseSeen)
      begin
        riseSeen = 1'b1;
        if (cycle - 1 - acceptCycle != latency)
        begin
          errors = errors + 1;
          $display("[FAIL] %s latency expected %0d actual %0d",
                   name, latency, cycle - 1 - acceptCycle);
        end
      end
      if (outValid && outReady)
      begin
        outCount = outCount + 1;
        busy     = 1'b0;
        riseSeen = 1'b0;
        if (expQ.size() == 0)
        begin
          errors = errors + 1;
          $display("%s transferred with no block outstanding", name);
        end
        else
        begin
          expected = expQ.pop_front();
          tests = tests + 1;
          if (outData !== expected)
          begin
            errors = errors + 1;
            $display("[FAIL] %s expected %h actual %h", name, expected, outData);
          end
          else
            $display("[PASS] %s", name);
        end
      end
      if (inValid && inReady)
      begin
        expQ.push_back(aesRef(inData.plaintext, inData.key));
        busy        = 1'b1;
        acceptCycle = cycle;
      end
    end
  end

endmodule : aesChecker

`default_nettype wire

// File: design/aesEncryptTop.sv
//////////////////////////////////////////////////////////////////////
// AES-128 iterative encryption engine, one round per clock
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesEncryptTop (
  input  logic                clock,
  input  logic                arstN,
  input  aesTypesPkg::aesIn_t inData,
  input  logic                inValid,
  output logic                inReady,
  output aesTypesPkg::block_t outData,
  output logic                outValid,
  input  logic                outReady
);

  aesTypesPkg::block_t    curState;
  aesTypesPkg::key_t      curKey;
  aesTypesPkg::roundIdx_t round;
  aesTypesPkg::block_t    roundOut;
  aesTypesPkg::key_t      nextKey;

  aesRoundCtrl ctrl (
    .clock    (clock),
    .arstN    (arstN),
    .inData   (inData),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady),
    .curState (curState),
    .curKey   (curKey),
    .round    (round),
    .roundOut (roundOut),
    .nextKey  (nextKey)
  );

  // Round datapath and key schedule run side by side each cycle
  aesRoundFunc roundFunc (
    .curState (curState),
    .round    (round),
    .roundOut (roundOut)
  );

  aesKeySchedule keySched (
    .curKey  (curKey),
    .round   (round),
    .nextKey (nextKey)
  );

endmodule : aesEncryptTop

`default_nettype wire

// File: design/aesRoundCtrl.sv
//////////////////////////////////////////////////////////////////////
// AES round controller
// Handshake FSM, state and key registers, AddRoundKey, round counter
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesRoundCtrl (
  input  logic                   clock,
  input  logic                   arstN,
  input  aesTypesPkg::aesIn_t    inData,
  input  logic                   inValid,
  output logic                   inReady,
  output aesTypesPkg::block_t    outData,
  output logic                   outValid,
  input  logic                   outReady,
  output aesTypesPkg::block_t    curState,
  output aesTypesPkg::key_t      curKey,
  output aesTypesPkg::roundIdx_t round,
  input  aesTypesPkg::block_t    roundOut,
  input  aesTypesPkg::key_t      nextKey
);

  aesTypesPkg::ctrlState_t ctrlState;
  aesTypesPkg::block_t     stateReg;
  aesTypesPkg::key_t       keyReg;
  aesTypesPkg::roundIdx_t  roundReg;
  logic                    accept;
  logic                    lastRound;

  assign accept    = inValid && inReady;
  assign lastRound = (roundReg == aesTypesPkg::roundIdx_t'(aesGfPkg::numRounds));

  assign inReady  = (ctrlState == aesTypesPkg::stIdle);
  assign outValid = (ctrlState == aesTypesPkg::stDone);
  assign outData  = stateReg;
  assign curState = stateReg;
  assign curKey   = keyReg;
  assign round    = roundReg;

  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      ctrlState <= aesTypesPkg::stIdle;
      roundReg  <= '0;
    end
    else
    begin
      case (ctrlState)
        aesTypesPkg::stIdle:
        begin
          if (inValid)
          begin
            ctrlState <= aesTypesPkg::stRun;
            roundReg  <= 4'd1;
          end
        end
        aesTypesPkg::stRun:
        begin
          if (lastRound)
          begin
            ctrlState <= aesTypesPkg::stDone;
            roundReg  <= '0;
          end
          else
            roundReg <= roundReg + 4'd1;
        end
        aesTypesPkg::stDone:
        begin
          // Hold the result until the sink takes it
          if (outReady)
            ctrlState <= aesTypesPkg::stIdle;
        end
        default:
        begin
          ctrlState <= aesTypesPkg::stIdle;
          roundReg  <= '0;
        end
      endcase
    end
  end

  // Round 0 whitening on acceptance, then one full round per cycle
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      stateReg <= inData.plaintext ^ inData.key;
      keyReg   <= inData.key;
    end
    else if (ctrlState == aesTypesPkg::stRun)
    begin
      stateReg <= roundOut ^ nextKey;
      keyReg   <= nextKey;
    end
  end

  aStallHold: assert property (@(posedge clock) disable iff (!arstN)
    (outValid && !outReady) |=> (outValid && $stable(outData)))
    else $error("output changed while stalled");

  aRoundBound: assert property (@(posedge clock) disable iff (!arstN)
    roundReg <= aesTypesPkg::roundIdx_t'(aesGfPkg::numRounds))
    else $error("round counter out of range");

  aChanExcl: assert property (@(posedge clock) disable iff (!arstN)
    accept |=> (!inReady until_with (outValid && outReady)))
    else $error("input channel reopened before the output transfer");

endmodule : aesRoundCtrl

`default_nettype wire

// File: design/aesKeySchedule.sv
//////////////////////////////////////////////////////////////////////
// AES-128 key schedule step
// Derives the key of the given round from the previous round key
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesKeySchedule (
  input  aesTypesPkg::key_t      curKey,
  input  aesTypesPkg::roundIdx_t round,
  output aesTypesPkg::key_t      nextKey
);

  logic [31:0] w  [4];
  logic [31:0] nw [4];
  logic [31:0] temp;
  logic [7:0]  rconByte;
  logic        roundInRange;

  assign roundInRange = (round >= 4'd1) &&
                        (round <= aesTypesPkg::roundIdx_t'(aesGfPkg::numRounds));

  // Outside rounds 1..10 the key schedule output is ignored by the controller
  assign rconByte = roundInRange ? aesGfPkg::rcon[round - 4'd1] : 8'h00;

  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      w[i] = curKey[127 - 32*i -: 32];
    end
    // RotWord then SubWord on the last word
    temp = {aesGfPkg::sbox(w[3][23:16]),
            aesGfPkg::sbox(w[3][15:8]),
            aesGfPkg::sbox(w[3][7:0]),
            aesGfPkg::sbox(w[3][31:24])};
    temp[31:24] = temp[31:24] ^ rconByte;
    nw[0] = w[0] ^ temp;
    for (int i = 1; i < 4; i++)
    begin
      nw[i] = w[i] ^ nw[i - 1];
    end
    nextKey = {nw[0], nw[1], nw[2], nw[3]};
  end

endmodule : aesKeySchedule

`default_nettype wire

// File: design/aesRoundFunc.sv
//////////////////////////////////////////////////////////////////////
// AES round datapath
// SubBytes, ShiftRows and MixColumns (skipped in the last round)
//////////////////////////////////////////////////////////////////////
`default_nettype none

module aesRoundFunc (
  input  aesTypesPkg::block_t    curState,
  input  aesTypesPkg::roundIdx_t round,
  output aesTypesPkg::block_t    roundOut
);

  logic [7:0] subBytes [16];
  logic [7:0] shifted  [16];
  logic [7:0] mixed    [16];
  logic       lastRound;

  // One column times the fixed matrix {02 03 01 01}
  function automatic logic [31:0] mixColumn(input logic [31:0] col);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    {a0, a1, a2, a3} = col;
    return {aesGfPkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
            aesGfPkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
            aesGfPkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
            aesGfPkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
  endfunction

  assign lastRound = (round == aesTypesPkg::roundIdx_t'(aesGfPkg::numRounds));

  always_comb
  begin
    for (int i = 0; i < 16; i++)
    begin
      subBytes[i] = aesGfPkg::sbox(curState[127 - 8*i -: 8]);
    end
    // Byte 4c+r is row r of column c; row r rotates left by r
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[4*c + r] = subBytes[4*((c + r) % 4) + r];
      end
    end
    for (int c = 0; c < 4; c++)
    begin
      {mixed[4*c], mixed[4*c + 1], mixed[4*c + 2], mixed[4*c + 3]} =
        mixColumn({shifted[4*c], shifted[4*c + 1], shifted[4*c + 2], shifted[4*c + 3]});
    end
    for (int i = 0; i < 16; i++)
    begin
      roundOut[127 - 8*i -: 8] = lastRound ? shifted[i] : mixed[i];
    end
  end

endmodule : aesRoundFunc

`default_nettype wire

// File: design/aesGfPkg.sv
//////////////////////////////////////////////////////////////////////
// AES field arithmetic
// GF(2^8) helpers, S-box, round constants and the AES-128 round count
//////////////////////////////////////////////////////////////////////
`default_nettype none

package aesGfPkg;

  localparam int unsigned numRounds = 10;

  // Round constants for rounds 1 to 10
  localparam logic [7:0] rcon [10] = '{
    8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
    8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
  };

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Shift-and-add multiply in GF(2^8)
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        acc = acc ^ sh;
      sh = xtime(sh);
    end
    return acc;
  endfunction

  function automatic logic [7:0] sbox(input logic [7:0] b);
    logic [7:0] sq;
    logic [7:0] inv;
    // Inverse as b^254, built from the squares b^2 .. b^128
    sq  = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      sq  = gfMul(sq, sq);
      inv = gfMul(inv, sq);
    end
    // Affine map
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

endpackage : aesGfPkg

`default_nettype wire

// File: design/aesTypesPkg.sv
//////////////////////////////////////////////////////////////////////
// AES data-shape types
// Block, key and channel types plus the controller state encoding
//////////////////////////////////////////////////////////////////////
`default_nettype none

package aesTypesPkg;

  // Byte 0 sits in bits 127:120, as in FIPS-197
  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;

  // Round number, 0 for the initial AddRoundKey up to 10
  typedef logic [3:0] roundIdx_t;

  // Input channel payload
  typedef struct packed {
    block_t plaintext;
    key_t   key;
  } aesIn_t;

  typedef enum logic [1:0] {
    stIdle,
    stRun,
    stDone
  } ctrlState_t;

endpackage : aesTypesPkg

`default_nettype wire
